// File: build.f
+incdir+rtl
+incdir+tests
rtl/aes_pkg.sv
rtl/aes_sbox.sv
rtl/aes_key_schedule.sv
rtl/aes_round.sv
rtl/aes_core.sv
tests/aes_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module aes_tb -f build.f --Mdir obj_dir -o sim

# The simulator exits nonzero on a failed check, the log decides the result
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log
then
	echo "Simulation reported a failure"
	exit 1
fi

grep -q "Regression passed" sim.log

// File: tests/aes_tb_vectors.svh
`ifndef AES_TB_VECTORS_SVH
`define AES_TB_VECTORS_SVH

// Known answers, one entry per column position: plaintext, key, ciphertext
// Entry 0 is FIPS-197 C.1, entry 1 is the Appendix B example, entry 2 is all zero
localparam int VEC_COUNT = 3;

typedef logic [1:0] vec_index_t;

localparam logic [0:VEC_COUNT-1][`AES_BLOCK_BITS-1:0] VEC_PLAINTEXT = {
	128'h00112233445566778899aabbccddeeff,
	128'h3243f6a8885a308d313198a2e0370734,
	128'h00000000000000000000000000000000
};

localparam logic [0:VEC_COUNT-1][`AES_BLOCK_BITS-1:0] VEC_KEY = {
	128'h000102030405060708090a0b0c0d0e0f,
	128'h2b7e151628aed2a6abf7158809cf4f3c,
	128'h00000000000000000000000000000000
};

localparam logic [0:VEC_COUNT-1][`AES_BLOCK_BITS-1:0] VEC_CIPHERTEXT = {
	128'h69c4e0d86a7b0430d8cdb78070b4c55a,
	128'h3925841d02dc09fbdc118597196a0b32,
	128'h66e94bd4ef8a2c3b884cfa59ca342b2e
};

`endif

// File: tests/aes_tb.sv
`timescale 1ns/100ps
`include "aes_defs.svh"

module aes_tb;

	`include "aes_tb_vectors.svh"

	localparam logic [31:0] SEED = 32'h4c9feab5;
	localparam int DONE_TIMEOUT = 4 * `AES_ROUNDS;

	logic clock;
	logic reset;
	logic start;
	logic [`AES_BLOCK_BITS-1:0] plaintext;
	logic [`AES_BLOCK_BITS-1:0] key;
	logic busy;
	logic done;
	logic [`AES_BLOCK_BITS-1:0] ciphertext;

	string test_name;
	logic [`AES_BLOCK_BITS-1:0] offered_ct;
	logic [`AES_BLOCK_BITS-1:0] pending_ct;
	logic [`AES_BLOCK_BITS-1:0] held_ct;
	logic running;
	int cycles_in_block;
	int done_count;
	int blocks_started;

	aes_core dut (
		.clock (clock),
		.reset (reset),
		.start (start),
		.plaintext (plaintext),
		.key (key),
		.busy (busy),
		.done (done),
		.ciphertext (ciphertext)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// ******************************
	// Failure reporting
	// ******************************

	task automatic end_in_failure();
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic show_mismatch(input logic [`AES_BLOCK_BITS-1:0] expected,
		input logic [`AES_BLOCK_BITS-1:0] actual);
		$display("Error %s: expected %h, actual %h", test_name, expected, actual);
		end_in_failure();
	endtask

	task automatic describe_problem(input string reason);
		$display("Error %s: %s", test_name, reason);
		end_in_failure();
	endtask

	// ******************************
	// Checks
	// ******************************

	assert property (@(posedge clock) disable iff (!reset) done |=> !done)
		else describe_problem("done lasted more than one cycle");

	assert property (@(posedge clock) disable iff (!reset) (start && !busy) |=> busy)
		else describe_problem("busy did not rise after an accepted start");

	// Tracks each accepted block from the edge that samples start
	always @(posedge clock)
	begin
		if (reset)
		begin
			if (running)
			begin
				cycles_in_block++;
				if (cycles_in_block <= `AES_ROUNDS)
				begin
					assert (busy) else describe_problem("busy low while a block runs");
					assert (!done) else describe_problem("done arrived before the last round");
				end
				else
				begin
					assert (done) else describe_problem("done missing after the last round");
					assert (!busy) else describe_problem("busy still high in the done cycle");
					assert (ciphertext == pending_ct) else show_mismatch(pending_ct, ciphertext);
					held_ct = pending_ct;
					running = 1'b0;
					done_count++;
				end
			end
			else
			begin
				assert (!busy) else describe_problem("busy high with no block in progress");
				assert (!done) else describe_problem("done with no block in progress");
			end
			if (!done)
			begin
				assert (ciphertext == held_ct) else show_mismatch(held_ct, ciphertext);
			end
			if (!busy && start)
			begin
				running = 1'b1;
				cycles_in_block = 0;
				pending_ct = offered_ct;
			end
		end
	end

	// ******************************
	// Stimulus
	// ******************************

	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic offer_block(input vec_index_t idx);
		start = 1'b1;
		plaintext = VEC_PLAINTEXT[idx];
		key = VEC_KEY[idx];
		offered_ct = VEC_CIPHERTEXT[idx];
		blocks_started++;
		@(posedge clock);
		#1;
		start = 1'b0;
	endtask

	// A start with a junk plaintext, offered while the core is busy
	task automatic inject_busy_start();
		start = 1'b1;
		plaintext = {$urandom(), $urandom(), $urandom(), $urandom()};
		@(posedge clock);
		#1;
		start = 1'b0;
	endtask

	// Returns in the done cycle, so the next start can follow at once
	task automatic wait_for_done();
		int waited;
		waited = 0;
		do
		begin
			@(posedge clock);
			#1;
			waited++;
			if (waited > DONE_TIMEOUT)
			begin
				describe_problem("timed out waiting for done");
			end
		end
		while (!done);
	endtask

	initial
	begin
		int gap;
		void'($urandom(SEED));
		reset = 1'b0;
		start = 1'b0;
		plaintext = '0;
		key = '0;
		offered_ct = '0;
		pending_ct = '0;
		held_ct = '0;
		running = 1'b0;
		cycles_in_block = 0;
		done_count = 0;
		blocks_started = 0;
		test_name = "reset";
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b1;
		idle_cycles(5);

		test_name = "known_answer";
		for (int i = 0; i < VEC_COUNT; i++)
		begin
			offer_block(vec_index_t'(i));
			wait_for_done();
			idle_cycles(2);
		end

		test_name = "start_while_busy";
		offer_block(vec_index_t'(1));
		gap = $urandom_range(8, 1);
		idle_cycles(gap);
		inject_busy_start();
		wait_for_done();
		idle_cycles(3);

		test_name = "back_to_back";
		offer_block(vec_index_t'(0));
		for (int i = 1; i < 7; i++)
		begin
			wait_for_done();
			offer_block(vec_index_t'(i % VEC_COUNT));
		end
		wait_for_done();

		test_name = "random_gaps";
		for (int i = 0; i < 8; i++)
		begin
			gap = $urandom_range(4, 0);
			idle_cycles(gap);
			offer_block(vec_index_t'(i % VEC_COUNT));
			wait_for_done();
		end
		idle_cycles(3);

		test_name = "done_count";
		if (done_count == blocks_started)
		begin
			$display("Regression passed");
			$finish;
		end
		else
		begin
			describe_problem($sformatf("expected %0d done pulses, actual %0d",
				blocks_started, done_count));
		end
	end

endmodule

// File: rtl/aes_core.sv
`timescale 1ns/100ps
`include "aes_defs.svh"

module aes_core (
	input logic clock,
	input logic reset,
	input logic start,
	input aes_pkg::block_t plaintext,
	input aes_pkg::block_t key,
	output logic busy,
	output logic done,
	output aes_pkg::block_t ciphertext
);

	import aes_pkg::*;

	ctrl_state_t ctrl_state;
	round_t round_cnt;

	block_t state_reg;
	block_t round_key;
	block_t next_state;

	logic load;
	logic advance;
	logic final_round;

	// Start only counts while idle, a start during a block is dropped
	assign load = (ctrl_state == CTRL_IDLE) && start;
	assign advance = (ctrl_state == CTRL_RUN);
	assign final_round = (round_cnt == round_t'(`AES_ROUNDS));
	assign busy = (ctrl_state == CTRL_RUN);

	// ******************************
	// Key schedule and round logic
	// ******************************

	aes_key_schedule u_key_schedule (
		.clock (clock),
		.reset (reset),
		.load (load),
		.advance (advance),
		.key (key),
		.round_key (round_key)
	);

	aes_round u_round (
		.state (state_reg),
		.round_key (round_key),
		.final_round (final_round),
		.next_state (next_state)
	);

	// ******************************
	// Controller
	// ******************************

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			ctrl_state <= CTRL_IDLE;
			round_cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (ctrl_state)
				CTRL_IDLE:
				begin
					if (start)
					begin
						ctrl_state <= CTRL_RUN;
						round_cnt <= round_t'(1);
					end
				end
				CTRL_RUN:
				begin
					if (final_round)
					begin
						ctrl_state <= CTRL_IDLE;
						done <= 1'b1;
					end
					else
					begin
						round_cnt <= round_cnt + round_t'(1);
					end
				end
			endcase
		end
	end

	// ******************************
	// Data path
	// ******************************

	// Initial AddRoundKey on load, then one round per cycle
	always_ff @(posedge clock)
	begin
		if (load)
		begin
			state_reg <= plaintext ^ key;
		end
		else if (advance)
		begin
			state_reg <= next_state;
		end
	end

	// Result holds until the next block finishes
	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			ciphertext <= '0;
		end
		else if (advance && final_round)
		begin
			ciphertext <= next_state;
		end
	end

endmodule

// File: rtl/aes_round.sv
`timescale 1ns/100ps
`include "aes_defs.svh"

module aes_round (
	input aes_pkg::block_t state,
	input aes_pkg::block_t round_key,
	input logic final_round,
	output aes_pkg::block_t next_state
);

	import aes_pkg::*;

	localparam int BYTES = `AES_BLOCK_BITS / `AES_BYTE_BITS;
	localparam int COLS = `AES_BLOCK_BITS / `AES_WORD_BITS;
	localparam int ROWS = `AES_WORD_BITS / `AES_BYTE_BITS;

	block_t sub_state;
	block_t shift_state;
	block_t mix_state;

	function automatic byte_t gf_triple(input byte_t value);
		return gf_double(value) ^ value;
	endfunction

	// One column times the circulant 2 3 1 1, row 0 in the top byte
	function automatic word_t mix_column(input word_t col);
		byte_t a0;
		byte_t a1;
		byte_t a2;
		byte_t a3;
		byte_t b0;
		byte_t b1;
		byte_t b2;
		byte_t b3;
		a0 = col[31:24];
		a1 = col[23:16];
		a2 = col[15:8];
		a3 = col[7:0];
		b0 = gf_double(a0) ^ gf_triple(a1) ^ a2 ^ a3;
		b1 = a0 ^ gf_double(a1) ^ gf_triple(a2) ^ a3;
		b2 = a0 ^ a1 ^ gf_double(a2) ^ gf_triple(a3);
		b3 = gf_triple(a0) ^ a1 ^ a2 ^ gf_double(a3);
		return {b0, b1, b2, b3};
	endfunction

	// ******************************
	// SubBytes
	// ******************************

	for (genvar i = 0; i < BYTES; i++)
	begin : g_sub_bytes
		aes_sbox u_sbox (
			.byte_in (state[i*`AES_BYTE_BITS +: `AES_BYTE_BITS]),
			.byte_out (sub_state[i*`AES_BYTE_BITS +: `AES_BYTE_BITS])
		);
	end

	// ******************************
	// ShiftRows
	// ******************************

	// Byte 0 sits in the top bits and the state is stored column by column
	// Row r rotates left by r columns
	for (genvar c = 0; c < COLS; c++)
	begin : g_shift_col
		for (genvar r = 0; r < ROWS; r++)
		begin : g_shift_row
			assign shift_state[`AES_BLOCK_BITS-1 - (ROWS*c + r)*`AES_BYTE_BITS
				-: `AES_BYTE_BITS] =
				sub_state[`AES_BLOCK_BITS-1 - (ROWS*((c + r) % COLS) + r)*`AES_BYTE_BITS
				-: `AES_BYTE_BITS];
		end
	end

	// ******************************
	// MixColumns and AddRoundKey
	// ******************************

	for (genvar c = 0; c < COLS; c++)
	begin : g_mix_col
		assign mix_state[`AES_BLOCK_BITS-1 - c*`AES_WORD_BITS -: `AES_WORD_BITS] =
			mix_column(shift_state[`AES_BLOCK_BITS-1 - c*`AES_WORD_BITS -: `AES_WORD_BITS]);
	end

	// The last round skips MixColumns
	always_comb
	begin
		if (final_round)
		begin
			next_state = shift_state ^ round_key;
		end
		else
		begin
			next_state = mix_state ^ round_key;
		end
	end

endmodule

// File: rtl/aes_key_schedule.sv
`timescale 1ns/100ps
`include "aes_defs.svh"

module aes_key_schedule (
	input logic clock,
	input logic reset,
	input logic load,
	input logic advance,
	input aes_pkg::block_t key,
	output aes_pkg::block_t round_key
);

	import aes_pkg::*;

	localparam int WORDS = `AES_BLOCK_BITS / `AES_WORD_BITS;
	localparam int WORD_BYTES = `AES_WORD_BITS / `AES_BYTE_BITS;

	block_t key_reg;
	byte_t rcon;

	word_t last_word;
	word_t rot_word;
	word_t sub_word;
	word_t temp_word;

	// ******************************
	// Next key expansion
	// ******************************

	assign last_word = key_reg[`AES_WORD_BITS-1:0];

	// RotWord moves the top byte to the bottom
	assign rot_word = {last_word[`AES_WORD_BITS-`AES_BYTE_BITS-1:0],
		last_word[`AES_WORD_BITS-1 -: `AES_BYTE_BITS]};

	for (genvar i = 0; i < WORD_BYTES; i++)
	begin : g_sub_word
		aes_sbox u_sbox (
			.byte_in (rot_word[i*`AES_BYTE_BITS +: `AES_BYTE_BITS]),
			.byte_out (sub_word[i*`AES_BYTE_BITS +: `AES_BYTE_BITS])
		);
	end

	// Round constant lands in the top byte only
	assign temp_word = sub_word ^ {rcon, {(`AES_WORD_BITS-`AES_BYTE_BITS){1'b0}}};

	// Each new word is the old word XOR the new word before it
	always_comb
	begin
		word_t chain;
		chain = temp_word;
		for (int i = 0; i < WORDS; i++)
		begin
			chain = chain ^ key_reg[`AES_BLOCK_BITS-1 - i*`AES_WORD_BITS -: `AES_WORD_BITS];
			round_key[`AES_BLOCK_BITS-1 - i*`AES_WORD_BITS -: `AES_WORD_BITS] = chain;
		end
	end

	// ******************************
	// Registers
	// ******************************

	// Runs 01, 02, 04 ... 80, 1b, 36 over the ten rounds
	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			rcon <= 8'h01;
		end
		else if (load)
		begin
			rcon <= 8'h01;
		end
		else if (advance)
		begin
			rcon <= gf_double(rcon);
		end
	end

	always_ff @(posedge clock)
	begin
		if (load)
		begin
			key_reg <= key;
		end
		else if (advance)
		begin
			key_reg <= round_key;
		end
	end

endmodule

// File: rtl/aes_sbox.sv
`timescale 1ns/100ps
`include "aes_defs.svh"

module aes_sbox (
	input aes_pkg::byte_t byte_in,
	output aes_pkg::byte_t byte_out
);

	import aes_pkg::*;

	// Additive constant of the affine step
	localparam byte_t AFFINE_CONST = 8'h63;

	byte_t inverse;

	// Shift and add multiplier over GF(2^8)
	function automatic byte_t gf_mul(input byte_t a, input byte_t b);
		byte_t acc;
		byte_t term;
		acc = '0;
		term = a;
		for (int i = 0; i < `AES_BYTE_BITS; i++)
		begin
			if (b[i])
			begin
				acc = acc ^ term;
			end
			term = gf_double(term);
		end
		return acc;
	endfunction

	// The inverse is x^254, built as x^2 * x^4 * ... * x^128
	// Zero stays zero, as the substitution requires
	function automatic byte_t gf_inverse(input byte_t x);
		byte_t power;
		byte_t result;
		power = x;
		result = 8'h01;
		for (int i = 1; i < `AES_BYTE_BITS; i++)
		begin
			power = gf_mul(power, power);
			result = gf_mul(result, power);
		end
		return result;
	endfunction

	// ******************************
	// Inverse then affine transform
	// ******************************

	assign inverse = gf_inverse(byte_in);

	// Each output bit sums the input bit with the four bits above it, cyclically
	always_comb
	begin
		byte_out = inverse
			^ {inverse[6:0], inverse[7]}
			^ {inverse[5:0], inverse[7:6]}
			^ {inverse[4:0], inverse[7:5]}
			^ {inverse[3:0], inverse[7:4]}
			^ AFFINE_CONST;
	end

endmodule

// File: rtl/aes_pkg.sv
`include "aes_defs.svh"

package aes_pkg;

	// ******************************
	// Data types
	// ******************************

	typedef logic [`AES_BLOCK_BITS-1:0] block_t;

	typedef logic [`AES_WORD_BITS-1:0] word_t;

	typedef logic [`AES_BYTE_BITS-1:0] byte_t;

	// Holds 1 to 10 while a block is in progress
	typedef logic [3:0] round_t;

	typedef enum logic
	{
		CTRL_IDLE,
		CTRL_RUN
	} ctrl_state_t;

	// ******************************
	// GF(2^8) arithmetic
	// ******************************

	// Low byte of the field polynomial x^8 + x^4 + x^3 + x + 1
	localparam byte_t GF_POLY = 8'h1b;

	// Multiplication by x, reduced when the top bit falls out
	function automatic byte_t gf_double(input byte_t value);
		byte_t shifted;
		shifted = {value[`AES_BYTE_BITS-2:0], 1'b0};
		if (value[`AES_BYTE_BITS-1])
		begin
			shifted = shifted ^ GF_POLY;
		end
		return shifted;
	endfunction

endpackage

// File: rtl/aes_defs.svh
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// Cipher block width, the key has the same width
`define AES_BLOCK_BITS 128

// One column of the state, also one word of the key
`define AES_WORD_BITS 32

// One byte of the state
`define AES_BYTE_BITS 8

// Full and final rounds after the initial key addition
`define AES_ROUNDS 10

`endif
